// File: Makefile
# Verilator build and run of the bus subsystem testbench

TOP := tcb_subsys_tb

.PHONY: sim clean

sim:
	verilator --binary -j 0 --top-module $(TOP) -f src.f -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir

// File: common/tcb_defines.svh
// bus widths, manager port count and data memory depth
// shared by the package and every RTL module

`ifndef TCB_DEFINES_SVH
`define TCB_DEFINES_SVH

// address width, byte address
`define TCB_AW 16

// data width
`define TCB_DW 32

// byte enable width, one bit per byte lane
`define TCB_BW (`TCB_DW/8)

// number of manager ports on the arbiter
`define TCB_PN 2

// data memory depth in words
`define TCB_MEM_WORDS 64

`endif

// File: common/tcb_pkg.sv
// bus field types and the port select type
// widths come from the defines header

`default_nettype none

`include "tcb_defines.svh"

package tcb_pkg;

  ////////////////////
  // bus fields
  ////////////////////

  // byte address
  typedef logic [`TCB_AW-1:0] tcb_adr_t;

  // data word, used for both write and read data
  typedef logic [`TCB_DW-1:0] tcb_dat_t;

  // byte enables, bit n covers data bits 8n+7..8n
  typedef logic [`TCB_BW-1:0] tcb_ben_t;

  ////////////////////
  // arbitration
  ////////////////////

  // manager port index
  typedef logic [$clog2(`TCB_PN)-1:0] tcb_sel_t;

endpackage : tcb_pkg

`default_nettype wire

// File: design/tcb_mem.sv
// on-chip data memory, bus subordinate
// one cycle from transfer to response
// byte enabled writes, range error above the memory depth

`timescale 1ns/1ps
`default_nettype none

`include "tcb_defines.svh"

module tcb_mem
  import tcb_pkg::*;
(
  // clock and synchronous reset
  input  wire  logic     man,
  input  wire  logic     reset,
  // request
  input  wire  logic     vld,
  input  wire  logic     wen,
  input  wire  tcb_adr_t adr,
  input  wire  tcb_ben_t ben,
  input  wire  tcb_dat_t wdt,
  output logic           rdy,
  // response
  output tcb_dat_t       rdt,
  output logic           err
);

  // word index width inside the array
  localparam int unsigned IW = $clog2(`TCB_MEM_WORDS);

  ////////////////////
  // local signals
  ////////////////////

  // storage
  tcb_dat_t mem [0:`TCB_MEM_WORDS-1];

  // word address, byte address without the two low bits
  logic [`TCB_AW-3:0] wrd_adr;

  // index into the array, valid only when in range
  logic [IW-1:0] idx;

  // address inside the memory
  logic in_rng;

  // handshake
  logic trn;

  ////////////////////
  // decode
  ////////////////////

  assign wrd_adr = adr[`TCB_AW-1:2];
  assign idx     = wrd_adr[IW-1:0];

  // upper word bits must select inside the depth
  assign in_rng  = (32'(wrd_adr) < 32'(`TCB_MEM_WORDS));

  assign trn     = vld & rdy;

  // always ready once out of reset
  // registered, so low on the first cycle after reset too
  always_ff @(posedge man) begin
    if (reset) begin
      rdy <= 1'b0;
    end else begin
      rdy <= 1'b1;
    end
  end

  ////////////////////
  // storage write
  ////////////////////

  // only enabled lanes change
  // out of range writes are dropped
  always_ff @(posedge man) begin
    if (trn && wen && in_rng) begin
      for (int b = 0; b < `TCB_BW; b++) begin
        if (ben[b]) begin
          mem[idx][8*b +: 8] <= wdt[8*b +: 8];
        end
      end
    end
  end

  ////////////////////
  // response
  ////////////////////

  // read data is zero on writes, errors and idle cycles
  // nonblocking read sees the word before a same cycle write
  always_ff @(posedge man) begin
    if (trn && !wen && in_rng) begin
      rdt <= mem[idx];
    end else begin
      rdt <= '0;
    end
  end

  // error only on the cycle after an out of range transfer
  always_ff @(posedge man) begin
    if (reset) begin
      err <= 1'b0;
    end else begin
      err <= trn & ~in_rng;
    end
  end

endmodule : tcb_mem

`default_nettype wire

// File: design/tcb_subsys.sv
// bus subsystem top level
// two managers share one data memory through the arbiter

`timescale 1ns/1ps
`default_nettype none

`include "tcb_defines.svh"

module tcb_subsys
  import tcb_pkg::*;
(
  // clock and synchronous reset
  input  wire  logic     man,
  input  wire  logic     reset,
  // manager ports, indexed by port number
  input  wire  logic     sub_vld [`TCB_PN-1:0],
  input  wire  logic     sub_wen [`TCB_PN-1:0],
  input  wire  tcb_adr_t sub_adr [`TCB_PN-1:0],
  input  wire  tcb_ben_t sub_ben [`TCB_PN-1:0],
  input  wire  tcb_dat_t sub_wdt [`TCB_PN-1:0],
  output logic           sub_rdy [`TCB_PN-1:0],
  output tcb_dat_t       sub_rdt [`TCB_PN-1:0],
  output logic           sub_err [`TCB_PN-1:0]
);

  ////////////////////
  // arbiter to memory
  ////////////////////

  // request, driven by the arbiter
  logic     man_vld;
  logic     man_wen;
  tcb_adr_t man_adr;
  tcb_ben_t man_ben;
  tcb_dat_t man_wdt;

  // ready and response, driven by the memory
  logic     man_rdy;
  tcb_dat_t man_rdt;
  logic     man_err;

  ////////////////////
  // arbiter
  ////////////////////

  tcb_arb tcb_arb_i (
    .man     (man),
    .reset   (reset),
    .sub_vld (sub_vld),
    .sub_wen (sub_wen),
    .sub_adr (sub_adr),
    .sub_ben (sub_ben),
    .sub_wdt (sub_wdt),
    .sub_rdy (sub_rdy),
    .sub_rdt (sub_rdt),
    .sub_err (sub_err),
    .man_vld (man_vld),
    .man_wen (man_wen),
    .man_adr (man_adr),
    .man_ben (man_ben),
    .man_wdt (man_wdt),
    .man_rdy (man_rdy),
    .man_rdt (man_rdt),
    .man_err (man_err)
  );

  ////////////////////
  // data memory
  ////////////////////

  tcb_mem tcb_mem_i (
    .man   (man),
    .reset (reset),
    .vld   (man_vld),
    .wen   (man_wen),
    .adr   (man_adr),
    .ben   (man_ben),
    .wdt   (man_wdt),
    .rdy   (man_rdy),
    .rdt   (man_rdt),
    .err   (man_err)
  );

endmodule : tcb_subsys

`default_nettype wire

// File: src.f
+incdir+common
common/tcb_pkg.sv
tcb_arb/tcb_arb.sv
design/tcb_mem.sv
design/tcb_subsys.sv
tb/tcb_checker.sv
tb/tcb_subsys_tb.sv

// File: tb/tcb_checker.sv
// bus subsystem checker
// shadow memory, winner prediction, response and reset checks
// error and check counters for the testbench top

`timescale 1ns/1ps
`default_nettype none

`include "tcb_defines.svh"

module tcb_checker
  import tcb_pkg::*;
(
  input  wire  logic     man,
  input  wire  logic     reset,
  // manager ports as seen at the DUT
  input  wire  logic     sub_vld [`TCB_PN-1:0],
  input  wire  logic     sub_wen [`TCB_PN-1:0],
  input  wire  tcb_adr_t sub_adr [`TCB_PN-1:0],
  input  wire  tcb_ben_t sub_ben [`TCB_PN-1:0],
  input  wire  tcb_dat_t sub_wdt [`TCB_PN-1:0],
  input  wire  logic     sub_rdy [`TCB_PN-1:0],
  input  wire  tcb_dat_t sub_rdt [`TCB_PN-1:0],
  input  wire  logic     sub_err [`TCB_PN-1:0],
  // running totals
  output int             err_cnt,
  output int             chk_cnt
);

  localparam int unsigned IW = $clog2(`TCB_MEM_WORDS);

  // expected memory contents
  tcb_dat_t shadow [0:`TCB_MEM_WORDS-1];

  int   errors   = 0;
  int   checks   = 0;
  // reset seen at the previous sample
  logic rst_prev = 1'b1;
  // response owed on the next sample
  logic pend     = 1'b0;
  int   pend_port;
  tcb_dat_t exp_rdt;
  logic     exp_err;

  assign err_cnt = errors;
  assign chk_cnt = checks;

  task automatic check_word(string name, int port, tcb_dat_t exp, tcb_dat_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED time %0t %s[%0d] expected %h actual %h",
               $time, name, port, exp, act);
    end
  endtask

  task automatic check_bit(string name, int port, logic exp, logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("CHECK FAILED time %0t %s[%0d] expected %b actual %b",
               $time, name, port, exp, act);
    end
  endtask

  // work out the response of one transfer and update the shadow on writes
  task automatic predict(int p);
    logic [`TCB_AW-3:0] wrd;
    wrd = sub_adr[p][`TCB_AW-1:2];
    exp_rdt = '0;
    exp_err = 1'b0;
    if (int'(wrd) >= `TCB_MEM_WORDS) begin
      exp_err = 1'b1;
    end else if (sub_wen[p]) begin
      for (int b = 0; b < `TCB_BW; b++) begin
        if (sub_ben[p][b]) begin
          shadow[wrd[IW-1:0]][8*b +: 8] = sub_wdt[p][8*b +: 8];
        end
      end
    end else begin
      exp_rdt = shadow[wrd[IW-1:0]];
    end
  endtask

  ////////////////////
  // sampling
  ////////////////////

  // sample on the falling edge where inputs and outputs are settled
  always @(negedge man) begin : sample
    int win;
    if (reset) begin
      for (int p = 0; p < `TCB_PN; p++) begin
        check_bit("sub_rdy", p, 1'b0, sub_rdy[p]);
        check_bit("sub_err", p, 1'b0, sub_err[p]);
      end
      pend = 1'b0;
    end else begin
      // response of the last transfer goes to its owner only
      if (pend) begin
        for (int p = 0; p < `TCB_PN; p++) begin
          check_word("sub_rdt", p, (p == pend_port) ? exp_rdt : '0, sub_rdt[p]);
          check_bit("sub_err", p, (p == pend_port) ? exp_err : 1'b0, sub_err[p]);
        end
      end
      // still quiet on the first cycle out of reset
      if (rst_prev) begin
        for (int p = 0; p < `TCB_PN; p++) begin
          check_bit("sub_rdy", p, 1'b0, sub_rdy[p]);
          check_bit("sub_err", p, 1'b0, sub_err[p]);
        end
      end
      // first valid port counting up from 0 wins
      win = -1;
      for (int p = 0; p < `TCB_PN; p++) begin
        if (sub_vld[p] && win < 0) begin
          win = p;
        end
      end
      for (int p = 0; p < `TCB_PN; p++) begin
        if (sub_vld[p]) begin
          check_bit("sub_rdy", p, (p == win) && !rst_prev, sub_rdy[p]);
        end
      end
      pend = 1'b0;
      if (win >= 0 && sub_rdy[win]) begin
        predict(win);
        pend      = 1'b1;
        pend_port = win;
      end
    end
    rst_prev = reset;
  end : sample

endmodule : tcb_checker

`default_nettype wire

// File: tb/tcb_subsys_tb.sv
// testbench top for the bus subsystem
// clock, reset, stimulus table with per port hold and retry
// watchdog, per test report and final summary

`timescale 1ns/1ps
`default_nettype none

`include "tcb_defines.svh"

module tcb_subsys_tb
  import tcb_pkg::*;
();

  // one manager request
  typedef struct packed {
    logic     vld;
    logic     wen;
    tcb_adr_t adr;
    tcb_ben_t ben;
    tcb_dat_t wdt;
  } req_t;

  // clock starts low
  logic     man = 1'b0;
  logic     reset;
  logic     sub_vld [`TCB_PN-1:0];
  logic     sub_wen [`TCB_PN-1:0];
  tcb_adr_t sub_adr [`TCB_PN-1:0];
  tcb_ben_t sub_ben [`TCB_PN-1:0];
  tcb_dat_t sub_wdt [`TCB_PN-1:0];
  logic     sub_rdy [`TCB_PN-1:0];
  tcb_dat_t sub_rdt [`TCB_PN-1:0];
  logic     sub_err [`TCB_PN-1:0];
  int       err_cnt;
  int       chk_cnt;

  // stimulus table with one entry per row
  req_t   req0_q [$];
  req_t   req1_q [$];
  int     test_q [$];
  int     n_rows = 0;
  integer seed   = 32'h4fb4;
  string  test_name [6] = '{"reset", "write_read", "byte_enables",
                            "contention", "range_error", "back_to_back"};
  int     err_mark     = 0;
  int     tests_passed = 0;
  int     tests_failed = 0;

  tcb_subsys tcb_subsys_i (.*);

  tcb_checker chk (.*);

  initial begin
    forever #2 man = ~man;
  end

  function automatic req_t no_req();
    return '0;
  endfunction

  function automatic req_t read_req(tcb_adr_t adr);
    return '{vld: 1'b1, wen: 1'b0, adr: adr, ben: '1, wdt: '0};
  endfunction

  function automatic req_t write_req(tcb_adr_t adr, tcb_ben_t ben, tcb_dat_t wdt);
    return '{vld: 1'b1, wen: 1'b1, adr: adr, ben: ben, wdt: wdt};
  endfunction

  task automatic add_row(int test, req_t r0, req_t r1);
    test_q.push_back(test);
    req0_q.push_back(r0);
    req1_q.push_back(r1);
  endtask

  ////////////////////
  // stimulus table
  ////////////////////

  task automatic build_table();
    // each port alone
    add_row(1, write_req(16'h0010, 4'hf, 32'h11223344), no_req());
    add_row(1, read_req(16'h0010), no_req());
    add_row(1, no_req(), write_req(16'h0020, 4'hf, tcb_dat_t'($random(seed))));
    add_row(1, no_req(), read_req(16'h0020));
    // full word first and then partial lanes from both ports
    add_row(2, write_req(16'h0030, 4'hf, tcb_dat_t'($random(seed))), no_req());
    add_row(2, write_req(16'h0030, 4'b0101, 32'haabbccdd), no_req());
    add_row(2, no_req(), write_req(16'h0030, 4'b1000, 32'h5a000000));
    add_row(2, no_req(), read_req(16'h0030));
    add_row(2, read_req(16'h0030), no_req());
    // port 1 has to wait when both are valid
    add_row(3, write_req(16'h0040, 4'hf, 32'hcafe0001), read_req(16'h0040));
    add_row(3, read_req(16'h0010), read_req(16'h0020));
    add_row(3, write_req(16'h0044, 4'hf, tcb_dat_t'($random(seed))),
            write_req(16'h0044, 4'b0011, 32'h0000beef));
    add_row(3, no_req(), read_req(16'h0044));
    // word 65 aliases word 1 in the low index bits
    add_row(4, write_req(16'h0004, 4'hf, 32'h01010101), no_req());
    add_row(4, no_req(), read_req(16'h0100));
    add_row(4, write_req(16'h0104, 4'hf, 32'hdeadbeef), no_req());
    add_row(4, read_req(16'h0004), no_req());
    add_row(4, no_req(), write_req(16'hfffc, 4'hf, 32'hffffffff));
    add_row(4, no_req(), read_req(16'h0004));
    // alternating ports with one transfer per cycle
    add_row(5, write_req(16'h0050, 4'hf, tcb_dat_t'($random(seed))), no_req());
    add_row(5, no_req(), write_req(16'h0054, 4'hf, tcb_dat_t'($random(seed))));
    add_row(5, read_req(16'h0054), no_req());
    add_row(5, no_req(), read_req(16'h0050));
    add_row(5, read_req(16'h0010), no_req());
    add_row(5, no_req(), read_req(16'h0020));
    n_rows = test_q.size();
  endtask

  task automatic drive_port(int p, req_t r);
    sub_vld[p] = r.vld;
    sub_wen[p] = r.wen;
    sub_adr[p] = r.adr;
    sub_ben[p] = r.ben;
    sub_wdt[p] = r.wdt;
  endtask

  // hold each refused port until it transfers
  task automatic apply_row(req_t r0, req_t r1);
    logic [`TCB_PN-1:0] pend;
    logic [`TCB_PN-1:0] got;
    drive_port(0, r0);
    drive_port(1, r1);
    pend = {r1.vld, r0.vld};
    if (pend == '0) begin
      @(posedge man);
      #1;
    end
    while (pend != '0) begin
      @(negedge man);
      got = '0;
      for (int p = 0; p < `TCB_PN; p++) begin
        if (pend[p] && sub_rdy[p]) begin
          got[p] = 1'b1;
        end
      end
      @(posedge man);
      #1;
      for (int p = 0; p < `TCB_PN; p++) begin
        if (got[p]) begin
          pend[p]    = 1'b0;
          sub_vld[p] = 1'b0;
        end
      end
    end
  endtask

  // let responses drain and report errors since the last test
  task automatic finish_test(int t);
    int errs;
    repeat (2) @(posedge man);
    #1;
    errs = err_cnt - err_mark;
    err_mark = err_cnt;
    if (errs == 0) begin
      tests_passed++;
      $display("test %0d %s: ok", t, test_name[t]);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", t, test_name[t], errs);
    end
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin : main
    int cur;
    reset = 1'b1;
    for (int p = 0; p < `TCB_PN; p++) begin
      drive_port(p, no_req());
    end
    build_table();
    repeat (5) @(posedge man);
    #1;
    reset = 1'b0;
    // covers reset and the first cycle after it
    finish_test(0);
    cur = test_q[0];
    for (int i = 0; i < n_rows; i++) begin
      if (test_q[i] != cur) begin
        finish_test(cur);
        cur = test_q[i];
      end
      apply_row(req0_q[i], req1_q[i]);
    end
    finish_test(cur);
    $display("summary: %0d tests ok, %0d tests with errors, %0d checks, %0d errors",
             tests_passed, tests_failed, chk_cnt, err_cnt);
    if (tests_failed == 0 && err_cnt == 0 && chk_cnt > 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end : main

  // four cycles per row plus reset at 4 ns each
  initial begin : watchdog
    wait (n_rows > 0);
    #((n_rows * 4 + 5) * 4);
    $display("watchdog: the run did not finish in time, a handshake hung");
    $display("Regression failed");
    $finish;
  end : watchdog

endmodule : tcb_subsys_tb

`default_nettype wire

// File: tcb_arb/tcb_arb.sv
// fixed priority arbiter for the tightly coupled bus
// request multiplexer, response demultiplexer
// port 0 always has the highest priority

`timescale 1ns/1ps
`default_nettype none

`include "tcb_defines.svh"

module tcb_arb
  import tcb_pkg::*;
(
  // clock and synchronous reset
  input  wire  logic     man,
  input  wire  logic     reset,
  // subordinate side, one set per manager
  input  wire  logic     sub_vld [`TCB_PN-1:0],
  input  wire  logic     sub_wen [`TCB_PN-1:0],
  input  wire  tcb_adr_t sub_adr [`TCB_PN-1:0],
  input  wire  tcb_ben_t sub_ben [`TCB_PN-1:0],
  input  wire  tcb_dat_t sub_wdt [`TCB_PN-1:0],
  output logic           sub_rdy [`TCB_PN-1:0],
  output tcb_dat_t       sub_rdt [`TCB_PN-1:0],
  output logic           sub_err [`TCB_PN-1:0],
  // manager side, toward the memory
  output logic           man_vld,
  output logic           man_wen,
  output tcb_adr_t       man_adr,
  output tcb_ben_t       man_ben,
  output tcb_dat_t       man_wdt,
  input  wire  logic     man_rdy,
  input  wire  tcb_dat_t man_rdt,
  input  wire  logic     man_err
);

  ////////////////////
  // priority encoder
  ////////////////////

  // lowest numbered valid port wins
  // scan from the top so the last hit is the lowest index
  // nothing valid gives port 0, whose vld is then low anyway
  function automatic tcb_sel_t pri_enc(input logic [`TCB_PN-1:0] vld);
    tcb_sel_t sel;
    sel = '0;
    for (int i = `TCB_PN-1; i >= 0; i--) begin
      if (vld[i]) begin
        sel = tcb_sel_t'(i);
      end
    end
    return sel;
  endfunction

  ////////////////////
  // local signals
  ////////////////////

  // valids gathered into one vector for the encoder
  logic [`TCB_PN-1:0] vld_vec;

  // live select, request phase
  tcb_sel_t sub_sel;

  // registered select, response phase
  tcb_sel_t man_sel;

  // transfer on the manager side
  logic trn;

  ////////////////////
  // arbiter
  ////////////////////

  // gather request valids
  for (genvar i = 0; i < `TCB_PN; i++) begin : gen_vld
    assign vld_vec[i] = sub_vld[i];
  end : gen_vld

  // same cycle decision, purely combinational
  assign sub_sel = pri_enc(vld_vec);

  // handshake completes when both are high
  assign trn = man_vld & man_rdy;

  // remember who owns the response of this transfer
  // idle cycles keep the old value, the memory answers zero then
  always_ff @(posedge man) begin
    if (reset) begin
      man_sel <= '0;
    end else if (trn) begin
      man_sel <= sub_sel;
    end
  end

  ////////////////////
  // request path
  ////////////////////

  // winner's request goes straight through
  // zero cycles from manager to memory
  assign man_vld = sub_vld[sub_sel];
  assign man_wen = sub_wen[sub_sel];
  assign man_adr = sub_adr[sub_sel];
  assign man_ben = sub_ben[sub_sel];
  assign man_wdt = sub_wdt[sub_sel];

  ////////////////////
  // response path
  ////////////////////

  for (genvar i = 0; i < `TCB_PN; i++) begin : gen_rsp
    // ready only to the live winner, losers are held off
    assign sub_rdy[i] = (sub_sel == tcb_sel_t'(i)) ? man_rdy : 1'b0;
    // read data and error follow the registered select
    // non selected ports see zero and no error
    assign sub_rdt[i] = (man_sel == tcb_sel_t'(i)) ? man_rdt : '0;
    assign sub_err[i] = (man_sel == tcb_sel_t'(i)) ? man_err : 1'b0;
  end : gen_rsp

endmodule : tcb_arb

`default_nettype wire
